// File: design/mem_pkg.sv
`default_nettype none

package mem_pkg;

   localparam int ADDR_W = 32;
   localparam int WORD_W = 32;
   localparam int LINE_W = 128;   // one cache line, also one memory beat

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [WORD_W-1:0] word_t;
   typedef logic [LINE_W-1:0] line_t;

   // opcodes on the L1-to-L2 ports and on the memory port
   typedef enum logic [3:0] {
      MEM_LD_LINE = 4'd0,
      MEM_ST_LINE = 4'd1
   } mem_op_t;

endpackage

`default_nettype wire

// File: design/cache_pkg.sv
`default_nettype none

package cache_pkg;
   import mem_pkg::*;

   localparam int L1_LINES   = 16;
   localparam int L2_LINES   = 64;
   localparam int L1_IDX_W   = $clog2(L1_LINES);
   localparam int L2_IDX_W   = $clog2(L2_LINES);
   localparam int LINE_OFF_W = $clog2(LINE_W / 8);
   localparam int L1_TAG_W   = ADDR_W - L1_IDX_W - LINE_OFF_W;
   localparam int L2_TAG_W   = ADDR_W - L2_IDX_W - LINE_OFF_W;

   typedef struct packed {
      logic [L1_TAG_W-1:0] tag;
      logic [L1_IDX_W-1:0] index;
      logic [1:0]          word_sel;   // word within the line
      logic [1:0]          offset;
   } l1_addr_t;

   typedef struct packed {
      logic [L2_TAG_W-1:0]   tag;
      logic [L2_IDX_W-1:0]   index;
      logic [LINE_OFF_W-1:0] offset;
   } l2_addr_t;

   // same address word, seen with the L1 or the L2 index split
   typedef union packed {
      addr_t    raw;
      l1_addr_t l1;
      l2_addr_t l2;
   } cache_addr_u;

   typedef logic [63:0] count_t;

   typedef enum logic [2:0] {
      FLUSH_IDLE       = 3'd0,
      WAIT_FOR_L1D_L1I = 3'd1,
      GOT_L1D          = 3'd2,
      GOT_L1I          = 3'd3,
      FLUSH_L2         = 3'd4
   } flush_state_t;

endpackage

`default_nettype wire

// File: design/flush_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module flush_ctrl import cache_pkg::*; (
   input  logic clk,
   input  logic reset,
   input  logic flush_req_l1i,
   input  logic flush_req_l1d,
   input  logic l1i_flush_complete,
   input  logic l1d_flush_complete,
   input  logic l2_flush_complete,
   output logic in_flush_mode,
   output logic l2_flush_start
);

   flush_state_t r_state, n_state;
   logic         n_flush;
   logic         n_start;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= FLUSH_IDLE;
         in_flush_mode <= 1'b0;
         l2_flush_start <= 1'b0;
      end
      else
      begin
         r_state <= n_state;
         in_flush_mode <= n_flush;
         l2_flush_start <= n_start;
      end
   end

   always_comb
   begin
      n_state = r_state;
      n_flush = in_flush_mode;
      n_start = 1'b0;
      case (r_state)
         FLUSH_IDLE:
         begin
            if (flush_req_l1i || flush_req_l1d)
               n_flush = 1'b1;
            if (flush_req_l1i && flush_req_l1d)
               n_state = WAIT_FOR_L1D_L1I;
            else if (flush_req_l1i)
               n_state = GOT_L1D;   // l1d not asked, counts as done
            else if (flush_req_l1d)
               n_state = GOT_L1I;
         end
         WAIT_FOR_L1D_L1I:
         begin
            if (l1d_flush_complete && l1i_flush_complete)
            begin
               n_state = FLUSH_L2;
               n_start = 1'b1;
            end
            else if (l1d_flush_complete)
               n_state = GOT_L1D;
            else if (l1i_flush_complete)
               n_state = GOT_L1I;
         end
         GOT_L1D, GOT_L1I:
         begin
            // one L1 is in, wait for the other
            if ((r_state == GOT_L1D && l1i_flush_complete) ||
                (r_state == GOT_L1I && l1d_flush_complete))
            begin
               n_state = FLUSH_L2;
               n_start = 1'b1;
            end
         end
         FLUSH_L2:
         begin
            if (l2_flush_complete)
            begin
               n_state = FLUSH_IDLE;
               n_flush = 1'b0;
            end
         end
         default:
            n_state = FLUSH_IDLE;
      endcase
   end

endmodule

`default_nettype wire

// File: design/l1i.sv
`timescale 1ns/10ps
`default_nettype none

module l1i import mem_pkg::*, cache_pkg::*; (
   input  logic   clk,
   input  logic   reset,
   input  logic   fetch_valid,
   input  addr_t  fetch_addr,
   input  logic   flush_req,
   input  logic   l2_rsp_valid,
   input  line_t  l2_load_data,
   output logic   fetch_rsp_valid,
   output word_t  fetch_insn,
   output logic   flush_complete,
   output logic   l2_req,
   output addr_t  l2_addr,
   output count_t cache_accesses,
   output count_t cache_hits
);

   line_t               r_data [L1_LINES];
   logic [L1_TAG_W-1:0] r_tag [L1_LINES];
   logic [L1_LINES-1:0] r_valid;

   cache_addr_u         req_a, r_miss_a;
   logic [L1_IDX_W-1:0] idx;
   logic                hit;
   logic                r_flush;

   assign req_a.raw = fetch_addr;
   assign idx = req_a.l1.index;
   assign hit = r_valid[idx] && (r_tag[idx] == req_a.l1.tag);
   assign l2_addr = {r_miss_a.raw[ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_valid <= '0;
         r_flush <= 1'b0;
         flush_complete <= 1'b0;
         fetch_rsp_valid <= 1'b0;
         l2_req <= 1'b0;
         cache_accesses <= '0;
         cache_hits <= '0;
      end
      else
      begin
         fetch_rsp_valid <= 1'b0;
         r_flush <= flush_req;
         flush_complete <= r_flush;   // two cycles after the request
         if (r_flush)
            r_valid <= '0;
         if (fetch_valid)
         begin
            cache_accesses <= cache_accesses + 1'b1;
            r_miss_a <= req_a;
            fetch_insn <= r_data[idx][req_a.l1.word_sel*WORD_W +: WORD_W];
            if (hit)
            begin
               cache_hits <= cache_hits + 1'b1;
               fetch_rsp_valid <= 1'b1;
            end
            else
               l2_req <= 1'b1;
         end
         if (l2_rsp_valid)
         begin
            l2_req <= 1'b0;
            r_data[r_miss_a.l1.index] <= l2_load_data;
            r_tag[r_miss_a.l1.index] <= r_miss_a.l1.tag;
            r_valid[r_miss_a.l1.index] <= 1'b1;
            fetch_insn <= l2_load_data[r_miss_a.l1.word_sel*WORD_W +: WORD_W];
            fetch_rsp_valid <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: design/l1d.sv
`timescale 1ns/10ps
`default_nettype none

module l1d import mem_pkg::*, cache_pkg::*; (
   input  logic    clk,
   input  logic    reset,
   input  logic    dreq_valid,
   input  logic    dreq_we,
   input  addr_t   dreq_addr,
   input  word_t   dreq_wdata,
   input  logic    flush_req,
   input  logic    l2_rsp_valid,
   input  line_t   l2_load_data,
   output logic    drsp_valid,
   output word_t   drsp_rdata,
   output logic    flush_complete,
   output logic    l2_req,
   output addr_t   l2_addr,
   output mem_op_t l2_opcode,
   output line_t   l2_store_data,
   output count_t  cache_accesses,
   output count_t  cache_hits
);

   line_t               r_data [L1_LINES];
   logic [L1_TAG_W-1:0] r_tag [L1_LINES];
   logic [L1_LINES-1:0] r_valid, r_dirty;

   cache_addr_u         req_a, r_req_a;
   logic [L1_IDX_W-1:0] idx, r_fidx;
   logic                r_we, r_wb, r_refill, r_flushing;
   word_t               r_wdata;
   line_t               fill_line;
   logic                hit, flush_dirty, flush_step;

   assign req_a.raw = dreq_addr;
   assign idx = req_a.l1.index;
   assign hit = r_valid[idx] && (r_tag[idx] == req_a.l1.tag);
   assign flush_dirty = r_valid[r_fidx] && r_dirty[r_fidx];
   // walk moves on when the line is clean or its writeback is answered
   assign flush_step = r_flushing && (l2_req ? l2_rsp_valid : !flush_dirty);

   always_comb
   begin
      fill_line = l2_load_data;
      if (r_we)
         fill_line[r_req_a.l1.word_sel*WORD_W +: WORD_W] = r_wdata;   // store miss
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_valid <= '0;
         r_dirty <= '0;
         r_wb <= 1'b0;
         r_refill <= 1'b0;
         r_flushing <= 1'b0;
         r_fidx <= '0;
         l2_req <= 1'b0;
         drsp_valid <= 1'b0;
         flush_complete <= 1'b0;
         cache_accesses <= '0;
         cache_hits <= '0;
      end
      else
      begin
         drsp_valid <= 1'b0;
         flush_complete <= 1'b0;
         if (dreq_valid)
         begin
            cache_accesses <= cache_accesses + 1'b1;
            if (hit)
            begin
               cache_hits <= cache_hits + 1'b1;
               drsp_valid <= 1'b1;
               drsp_rdata <= r_data[idx][req_a.l1.word_sel*WORD_W +: WORD_W];
               if (dreq_we)
               begin
                  r_data[idx][req_a.l1.word_sel*WORD_W +: WORD_W] <= dreq_wdata;
                  r_dirty[idx] <= 1'b1;
               end
            end
            else
            begin
               r_req_a <= req_a;
               r_we <= dreq_we;
               r_wdata <= dreq_wdata;
               l2_req <= 1'b1;
               r_wb <= r_dirty[idx];
               if (r_valid[idx] && r_dirty[idx])
               begin
                  // victim out first
                  l2_opcode <= MEM_ST_LINE;
                  l2_addr <= {r_tag[idx], idx, {LINE_OFF_W{1'b0}}};
                  l2_store_data <= r_data[idx];
               end
               else
               begin
                  l2_opcode <= MEM_LD_LINE;
                  l2_addr <= {dreq_addr[ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
               end
            end
         end
         if (l2_rsp_valid && !r_flushing)
         begin
            l2_req <= 1'b0;
            r_wb <= 1'b0;
            r_refill <= r_wb;
            if (!r_wb)
            begin
               r_data[r_req_a.l1.index] <= fill_line;
               r_tag[r_req_a.l1.index] <= r_req_a.l1.tag;
               r_valid[r_req_a.l1.index] <= 1'b1;
               r_dirty[r_req_a.l1.index] <= r_we;
               drsp_valid <= 1'b1;
               drsp_rdata <= l2_load_data[r_req_a.l1.word_sel*WORD_W +: WORD_W];
            end
         end
         if (r_refill)
         begin
            r_refill <= 1'b0;
            l2_req <= 1'b1;
            l2_opcode <= MEM_LD_LINE;
            l2_addr <= {r_req_a.raw[ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
         end
         if (flush_req)
         begin
            r_flushing <= 1'b1;
            r_fidx <= '0;
         end
         if (r_flushing && !l2_req && flush_dirty)
         begin
            l2_req <= 1'b1;
            l2_opcode <= MEM_ST_LINE;
            l2_addr <= {r_tag[r_fidx], r_fidx, {LINE_OFF_W{1'b0}}};
            l2_store_data <= r_data[r_fidx];
         end
         if (flush_step)
         begin
            l2_req <= 1'b0;
            r_valid[r_fidx] <= 1'b0;
            r_dirty[r_fidx] <= 1'b0;
            r_fidx <= r_fidx + 1'b1;
            if (&r_fidx)
            begin
               r_flushing <= 1'b0;
               flush_complete <= 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: design/l2.sv
`timescale 1ns/10ps
`default_nettype none

module l2 import mem_pkg::*, cache_pkg::*; (
   input  logic    clk,
   input  logic    reset,
   input  logic    l1i_req,
   input  addr_t   l1i_addr,
   input  logic    l1d_req,
   input  addr_t   l1d_addr,
   input  mem_op_t l1d_opcode,
   input  line_t   l1d_store_data,
   input  logic    l2_flush_start,
   input  logic    mem_rsp_valid,
   input  line_t   mem_rsp_load_data,
   output logic    l1i_rsp_valid,
   output logic    l1d_rsp_valid,
   output line_t   l1_load_data,
   output logic    l2_flush_complete,
   output logic    mem_req_valid,
   output addr_t   mem_req_addr,
   output mem_op_t mem_req_opcode,
   output line_t   mem_req_store_data,
   output count_t  cache_accesses,
   output count_t  cache_hits
);

   line_t               r_data [L2_LINES];
   logic [L2_TAG_W-1:0] r_tag [L2_LINES];
   logic [L2_LINES-1:0] r_valid, r_dirty;

   cache_addr_u         in_a, r_a, fill_a;
   logic [L2_IDX_W-1:0] in_idx, r_fidx;
   line_t               r_sdata, fill_line;
   logic                in_st, r_st, r_sel_d, fill_to_d;
   logic                r_busy, r_wb, r_rd_pend, r_flushing;
   logic                accept, hit, victim_dirty, direct, mem_done;
   logic                fill_en, fill_dirty, flush_dirty, flush_step;

   assign in_a.raw = l1d_req ? l1d_addr : l1i_addr;   // data cache wins a tie
   assign in_idx = in_a.l2.index;
   assign in_st = l1d_req && (l1d_opcode == MEM_ST_LINE);
   // requests are still high during their response pulse
   assign accept = (l1d_req || l1i_req) && !r_busy && !r_flushing &&
                   !l1i_rsp_valid && !l1d_rsp_valid;
   assign hit = r_valid[in_idx] && (r_tag[in_idx] == in_a.l2.tag);
   assign victim_dirty = r_valid[in_idx] && r_dirty[in_idx];
   assign direct = hit || (in_st && !victim_dirty);   // full line store needs no refill
   assign mem_done = r_busy && mem_rsp_valid;
   assign flush_dirty = r_valid[r_fidx] && r_dirty[r_fidx];
   assign flush_step = r_flushing && (mem_req_valid ? mem_rsp_valid : !flush_dirty);

   // line install and L1 response, from a direct hit or a finished miss
   always_comb
   begin
      fill_en = 1'b0;
      fill_a = r_a;
      fill_to_d = r_sel_d;
      fill_dirty = r_st;
      fill_line = r_st ? r_sdata : mem_rsp_load_data;
      if (accept && direct)
      begin
         fill_en = 1'b1;
         fill_a = in_a;
         fill_to_d = l1d_req;
         fill_dirty = in_st || r_dirty[in_idx];
         fill_line = in_st ? l1d_store_data : r_data[in_idx];
      end
      else if (mem_done && (r_st || !r_wb))
         fill_en = 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_valid <= '0;
         r_dirty <= '0;
         r_busy <= 1'b0;
         r_wb <= 1'b0;
         r_rd_pend <= 1'b0;
         r_flushing <= 1'b0;
         r_fidx <= '0;
         mem_req_valid <= 1'b0;
         l1i_rsp_valid <= 1'b0;
         l1d_rsp_valid <= 1'b0;
         l2_flush_complete <= 1'b0;
         cache_accesses <= '0;
         cache_hits <= '0;
      end
      else
      begin
         l1i_rsp_valid <= 1'b0;
         l1d_rsp_valid <= 1'b0;
         l2_flush_complete <= 1'b0;
         if (accept)
         begin
            cache_accesses <= cache_accesses + 1'b1;
            if (hit)
               cache_hits <= cache_hits + 1'b1;
            if (!direct)
            begin
               r_busy <= 1'b1;
               r_a <= in_a;
               r_st <= in_st;
               r_sel_d <= l1d_req;
               r_sdata <= l1d_store_data;
               r_wb <= victim_dirty;
               mem_req_valid <= 1'b1;
               if (victim_dirty)
               begin
                  mem_req_opcode <= MEM_ST_LINE;
                  mem_req_addr <= {r_tag[in_idx], in_idx, {LINE_OFF_W{1'b0}}};
                  mem_req_store_data <= r_data[in_idx];
               end
               else
               begin
                  mem_req_opcode <= MEM_LD_LINE;
                  mem_req_addr <= {in_a.raw[ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
               end
            end
         end
         if (mem_done)
         begin
            mem_req_valid <= 1'b0;
            r_wb <= 1'b0;
            r_rd_pend <= r_wb && !r_st;   // load miss still needs its line
            r_busy <= r_wb && !r_st;
         end
         if (r_rd_pend)
         begin
            r_rd_pend <= 1'b0;
            mem_req_valid <= 1'b1;
            mem_req_opcode <= MEM_LD_LINE;
            mem_req_addr <= {r_a.raw[ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
         end
         if (fill_en)
         begin
            r_data[fill_a.l2.index] <= fill_line;
            r_tag[fill_a.l2.index] <= fill_a.l2.tag;
            r_valid[fill_a.l2.index] <= 1'b1;
            r_dirty[fill_a.l2.index] <= fill_dirty;
            l1_load_data <= fill_line;
            l1d_rsp_valid <= fill_to_d;
            l1i_rsp_valid <= !fill_to_d;
         end
         if (l2_flush_start)
         begin
            r_flushing <= 1'b1;
            r_fidx <= '0;
         end
         if (r_flushing && !mem_req_valid && flush_dirty)
         begin
            mem_req_valid <= 1'b1;
            mem_req_opcode <= MEM_ST_LINE;
            mem_req_addr <= {r_tag[r_fidx], r_fidx, {LINE_OFF_W{1'b0}}};
            mem_req_store_data <= r_data[r_fidx];
         end
         if (flush_step)
         begin
            mem_req_valid <= 1'b0;
            r_dirty[r_fidx] <= 1'b0;   // line stays valid
            r_fidx <= r_fidx + 1'b1;
            if (&r_fidx)
            begin
               r_flushing <= 1'b0;
               l2_flush_complete <= 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: design/cache_hier.sv
`timescale 1ns/10ps
`default_nettype none

module cache_hier import mem_pkg::*, cache_pkg::*; (
   input  logic    clk,
   input  logic    reset,
   input  logic    fetch_valid,
   input  addr_t   fetch_addr,
   output logic    fetch_rsp_valid,
   output word_t   fetch_insn,
   input  logic    dreq_valid,
   input  logic    dreq_we,
   input  addr_t   dreq_addr,
   input  word_t   dreq_wdata,
   output logic    drsp_valid,
   output word_t   drsp_rdata,
   input  logic    flush_req_l1i,
   input  logic    flush_req_l1d,
   output logic    in_flush_mode,
   output logic    mem_req_valid,
   output addr_t   mem_req_addr,
   output mem_op_t mem_req_opcode,
   output line_t   mem_req_store_data,
   input  logic    mem_rsp_valid,
   input  line_t   mem_rsp_load_data,
   output count_t  l1i_cache_accesses,
   output count_t  l1i_cache_hits,
   output count_t  l1d_cache_accesses,
   output count_t  l1d_cache_hits,
   output count_t  l2_cache_accesses,
   output count_t  l2_cache_hits
);

   logic    l1i_req, l1d_req;
   addr_t   l1i_addr, l1d_addr;
   mem_op_t l1d_opcode;
   line_t   l1d_store_data;
   logic    l1i_rsp_valid, l1d_rsp_valid;
   line_t   l1_load_data;   // shared refill bus
   logic    l1i_flush_complete, l1d_flush_complete;
   logic    l2_flush_start, l2_flush_complete;

   flush_ctrl i_flush_ctrl (.*);

   l1i i_l1i (
      .clk, .reset, .fetch_valid, .fetch_addr,
      .flush_req(flush_req_l1i),
      .l2_rsp_valid(l1i_rsp_valid),
      .l2_load_data(l1_load_data),
      .fetch_rsp_valid, .fetch_insn,
      .flush_complete(l1i_flush_complete),
      .l2_req(l1i_req),
      .l2_addr(l1i_addr),
      .cache_accesses(l1i_cache_accesses),
      .cache_hits(l1i_cache_hits)
   );

   l1d i_l1d (
      .clk, .reset, .dreq_valid, .dreq_we, .dreq_addr, .dreq_wdata,
      .flush_req(flush_req_l1d),
      .l2_rsp_valid(l1d_rsp_valid),
      .l2_load_data(l1_load_data),
      .drsp_valid, .drsp_rdata,
      .flush_complete(l1d_flush_complete),
      .l2_req(l1d_req),
      .l2_addr(l1d_addr),
      .l2_opcode(l1d_opcode),
      .l2_store_data(l1d_store_data),
      .cache_accesses(l1d_cache_accesses),
      .cache_hits(l1d_cache_hits)
   );

   l2 i_l2 (
      .clk, .reset,
      .l1i_req, .l1i_addr,
      .l1d_req, .l1d_addr, .l1d_opcode, .l1d_store_data,
      .l2_flush_start, .l2_flush_complete,
      .l1i_rsp_valid, .l1d_rsp_valid, .l1_load_data,
      .mem_req_valid, .mem_req_addr, .mem_req_opcode, .mem_req_store_data,
      .mem_rsp_valid, .mem_rsp_load_data,
      .cache_accesses(l2_cache_accesses),
      .cache_hits(l2_cache_hits)
   );

endmodule

`default_nettype wire

// File: testbench/tb_cache_hier.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cache_hier
   import mem_pkg::*, cache_pkg::*;
();

   localparam int SEED        = 54232;
   localparam int N_LOADS     = 24;
   localparam int N_ROUNDS    = 8;   // five data ops each
   localparam int N_FETCHES   = 8;
   localparam int N_STORES    = 4;
   localparam int N_OPS       = N_LOADS + 5*N_ROUNDS + N_FETCHES + 2 + N_STORES + 2 + 2;
   localparam int N_FLUSHES   = 4;
   localparam int CYCLE_LIMIT = N_OPS*40 + N_FLUSHES*L1_LINES*40;

   logic    clk, reset;
   logic    fetch_valid, fetch_rsp_valid;
   addr_t   fetch_addr;
   word_t   fetch_insn;
   logic    dreq_valid, dreq_we, drsp_valid;
   addr_t   dreq_addr;
   word_t   dreq_wdata, drsp_rdata;
   logic    flush_req_l1i, flush_req_l1d, in_flush_mode;
   logic    mem_req_valid, mem_rsp_valid;
   addr_t   mem_req_addr;
   mem_op_t mem_req_opcode;
   line_t   mem_req_store_data, mem_rsp_load_data;
   count_t  l1i_cache_accesses, l1i_cache_hits;
   count_t  l1d_cache_accesses, l1d_cache_hits;
   count_t  l2_cache_accesses, l2_cache_hits;

   line_t   mem [addr_t];      // keyed by line address
   word_t   shadow [addr_t];   // every stored word
   addr_t   stored_q[$];
   word_t   d_exp_q[$], f_exp_q[$];
   bit      d_chk_q[$];        // 0 for a store response
   string   test_name;
   int      n_dreq, n_fetch, cycle_cnt, mem_wait;
   bit      is_ld;
   word_t   exp_w;

   cache_hier i_dut (.*);

   always #50 clk = ~clk;

   function automatic word_t ref_word(addr_t a);
      return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
   endfunction

   // expected word, last store wins over the initial pattern
   function automatic word_t exp_word(addr_t a);
      return shadow.exists(a) ? shadow[a] : ref_word(a);
   endfunction

   function automatic line_t exp_line(addr_t la);
      line_t l;
      for (int w = 0; w < 4; w++)
         l[w*WORD_W +: WORD_W] = exp_word(la + 4*w);
      return l;
   endfunction

   function automatic line_t mem_line(addr_t la);
      line_t l;
      if (mem.exists(la))
         l = mem[la];
      else
         for (int w = 0; w < 4; w++)
            l[w*WORD_W +: WORD_W] = ref_word(la + 4*w);
      return l;
   endfunction

   task automatic abort_run();
      $display("Verification failed");
      $fatal(1, "run aborted");
   endtask

   task automatic check_word(string name, word_t exp, word_t act);
      if (act !== exp)
      begin
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_count(string name, count_t exp, count_t act);
      if (act !== exp)
      begin
         $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_line(string name, line_t exp, line_t act);
      if (act !== exp)
      begin
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #10;
   endtask

   task automatic start_test(string name);
      next_cycle();   // last response already checked at the negedge
      test_name = name;
   endtask

   task automatic finish_data_req();
      next_cycle();
      dreq_valid = 1'b0;
      while (!drsp_valid)
         next_cycle();
      n_dreq++;
   endtask

   task automatic load_word(addr_t a);
      d_exp_q.push_back(exp_word(a));
      d_chk_q.push_back(1'b1);
      dreq_valid = 1'b1;
      dreq_we = 1'b0;
      dreq_addr = a;
      finish_data_req();
   endtask

   task automatic store_word(addr_t a, word_t w);
      shadow[a] = w;
      stored_q.push_back(a);
      d_exp_q.push_back(w);
      d_chk_q.push_back(1'b0);
      dreq_valid = 1'b1;
      dreq_we = 1'b1;
      dreq_addr = a;
      dreq_wdata = w;
      finish_data_req();
   endtask

   task automatic fetch_word(addr_t a);
      f_exp_q.push_back(exp_word(a));
      fetch_valid = 1'b1;
      fetch_addr = a;
      next_cycle();
      fetch_valid = 1'b0;
      while (!fetch_rsp_valid)
         next_cycle();
      n_fetch++;
   endtask

   task automatic run_flush(bit do_i, bit do_d);
      flush_req_l1i = do_i;
      flush_req_l1d = do_d;
      next_cycle();
      flush_req_l1i = 1'b0;
      flush_req_l1d = 1'b0;
      if (!in_flush_mode)
      begin
         $display("in_flush_mode did not rise after a flush request");
         abort_run();
      end
      while (in_flush_mode)
         next_cycle();
   endtask

   task automatic check_memory();
      addr_t la;
      foreach (stored_q[i])
      begin
         la = {stored_q[i][ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
         check_line(test_name, exp_line(la), mem_line(la));
      end
   endtask

   // memory model, 1 to 4 cycles per request
   always @(posedge clk)
   begin
      #10;
      if (reset || mem_rsp_valid || !mem_req_valid)
      begin
         mem_rsp_valid = 1'b0;
         mem_wait = 0;
      end
      else
      begin
         if (mem_wait == 0)
            mem_wait = 1 + int'($urandom % 4);
         mem_wait--;
         if (mem_wait == 0)
         begin
            if (mem_req_opcode == MEM_ST_LINE)
               mem[mem_req_addr] = mem_req_store_data;
            else
               mem_rsp_load_data = mem_line(mem_req_addr);
            mem_rsp_valid = 1'b1;
         end
      end
   end

   // response checker
   always @(negedge clk)
   begin
      if (drsp_valid === 1'b1)
      begin
         if (d_exp_q.size() == 0)
         begin
            $display("data response arrived with no request outstanding");
            abort_run();
         end
         else
         begin
            is_ld = d_chk_q.pop_front();
            exp_w = d_exp_q.pop_front();
            if (is_ld)
               check_word(test_name, exp_w, drsp_rdata);
         end
      end
      if (fetch_rsp_valid === 1'b1)
      begin
         if (f_exp_q.size() == 0)
         begin
            $display("fetch response arrived with no request outstanding");
            abort_run();
         end
         else
            check_word(test_name, f_exp_q.pop_front(), fetch_insn);
      end
   end

   always @(posedge clk)
   begin
      cycle_cnt++;
      if (cycle_cnt > CYCLE_LIMIT)
      begin
         $display("simulation timed out after %0d cycles", cycle_cnt);
         abort_run();
      end
   end

   initial
   begin
      addr_t  a, fa;
      count_t acc0, hit0, l2_acc0, l2_hit0;
      void'($urandom(SEED));
      clk = 1'b0;
      reset = 1'b1;
      fetch_valid = 1'b0;
      fetch_addr = '0;
      dreq_valid = 1'b0;
      dreq_we = 1'b0;
      dreq_addr = '0;
      dreq_wdata = '0;
      flush_req_l1i = 1'b0;
      flush_req_l1d = 1'b0;
      mem_rsp_valid = 1'b0;
      mem_rsp_load_data = '0;
      n_dreq = 0;
      n_fetch = 0;
      cycle_cnt = 0;
      mem_wait = 0;
      repeat (2) @(posedge clk);
      #10;
      reset = 1'b0;

      start_test("load after reset");
      for (int i = 0; i < N_LOADS; i++)
         load_word($urandom & 32'h0000_fffc);

      start_test("store then load");
      for (int i = 0; i < N_ROUNDS; i++)
      begin
         a = $urandom & 32'h0000_3ffc;
         store_word(a, $urandom);
         store_word(a + 32'd1024, $urandom);   // same L1 and L2 index
         load_word(a);
         load_word(a + 32'd1024);
         load_word(a + 32'd256);   // same L1 index only
      end

      start_test("full flush");
      run_flush(1'b1, 1'b1);
      check_memory();

      start_test("fetch");
      fa = '0;
      for (int i = 0; i < N_FETCHES; i++)
      begin
         fa = 32'h0010_0000 | ($urandom & 32'h0000_0ffc);
         fetch_word(fa);
      end
      store_word(fa, $urandom);   // l1i still holds the old word

      start_test("fetch after full flush");
      run_flush(1'b1, 1'b1);
      check_memory();
      fetch_word(fa);

      start_test("l1d only flush");
      for (int i = 0; i < N_STORES; i++)
         store_word($urandom & 32'h0000_fffc, $urandom);
      run_flush(1'b0, 1'b1);
      check_memory();

      start_test("l1d counters");
      a = $urandom & 32'h0000_fffc;
      acc0 = l1d_cache_accesses;
      hit0 = l1d_cache_hits;
      l2_acc0 = l2_cache_accesses;
      load_word(a);
      load_word(a);
      check_count("l1d accesses", acc0 + 64'd2, l1d_cache_accesses);
      check_count("l1d hits", hit0 + 64'd1, l1d_cache_hits);
      check_count("l2 accesses from l1d", l2_acc0 + 64'd1, l2_cache_accesses);   // first load only

      start_test("l1i only flush");
      run_flush(1'b1, 1'b0);
      check_memory();
      acc0 = l1i_cache_accesses;
      hit0 = l1i_cache_hits;
      l2_acc0 = l2_cache_accesses;
      l2_hit0 = l2_cache_hits;
      fetch_word(a);   // line still valid in l2 after its flush
      fetch_word(a ^ 32'h8);   // other word, same line
      check_count("l1i accesses", acc0 + 64'd2, l1i_cache_accesses);
      check_count("l1i hits", hit0 + 64'd1, l1i_cache_hits);
      check_count("l2 accesses from l1i", l2_acc0 + 64'd1, l2_cache_accesses);
      check_count("l2 hits from l1i", l2_hit0 + 64'd1, l2_cache_hits);

      start_test("final counts");
      check_count("l1d total accesses", count_t'(n_dreq), l1d_cache_accesses);
      check_count("l1i total accesses", count_t'(n_fetch), l1i_cache_accesses);
      if (d_exp_q.size() != 0 || f_exp_q.size() != 0)
      begin
         $display("responses still outstanding at the end of the run");
         abort_run();
      end
      else
      begin
         $display("Verification passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: cache_hier.f
design/mem_pkg.sv
design/cache_pkg.sv
design/flush_ctrl.sv
design/l1i.sv
design/l1d.sv
design/l2.sv
design/cache_hier.sv
testbench/tb_cache_hier.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_cache_hier -f cache_hier.f

# print the run output and fail unless the pass line was seen
./obj_dir/Vtb_cache_hier | awk '{ print } $0 == "Verification passed" { ok = 1 } END { exit !ok }'
